// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module tb_fcp_link -f src.f

./obj_dir/Vtb_fcp_link 2>&1 | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"

// ==== src.f ====
fcp_link_pkg.sv
fcp_ingress_packer.sv
fcp_beat_queue.sv
fcp_egress_unpacker.sv
fcp_rate_meter.sv
fcp_link_top.sv
fcp_link_assert.sv
tb_fcp_link.sv

// ==== tb_fcp_link.sv ====
// Directed testbench for fcp_link_top, compiled as the simulation top with its assertions bound
module tb_fcp_link;
    timeunit 1ns;
    timeprecision 1ps;
    import fcp_link_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int STIM_DELAY   = 1;
    localparam int RESET_CYCLES = 10;
    localparam int SEED         = 32'h95b4;
    // Test lengths in cycles summed for the watchdog
    localparam int LEN_HOLDOFF  = HOLDOFF_CYCLES + 16;
    localparam int LEN_LATENCY  = 40;
    localparam int LEN_STALL    = 60;
    localparam int LEN_OVERFLOW = 80;
    localparam int LEN_METER    = 3 * RATE_WINDOW_CYCLES + 30;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + LEN_HOLDOFF + LEN_LATENCY + LEN_STALL
                                   + LEN_OVERFLOW + LEN_METER + 200;

    logic     user_clk;
    logic     rst_user_300;
    fcp_msg_t fcp_in;
    logic     drain_en;
    fcp_msg_t fcp_out;
    logic     link_up;
    count_t   drop_count;
    total_t   total_count;
    count_t   msg_rate;

    // Expected messages in delivery order
    fcp_msg_t    model_q[$];
    total_t      exp_total = '0;
    int          delivered = 0;
    string       test_name;
    int          errors = 0;
    int          test_err_start;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int unsigned seed_ret;

    fcp_link_top dut_i (
        .user_clk     (user_clk),
        .rst_user_300 (rst_user_300),
        .fcp_in       (fcp_in),
        .drain_en     (drain_en),
        .fcp_out      (fcp_out),
        .link_up      (link_up),
        .drop_count   (drop_count),
        .total_count  (total_count),
        .msg_rate     (msg_rate)
    );

    initial begin
        user_clk = 1'b0;
        forever #(CLK_PERIOD / 2) user_clk = ~user_clk;
    end

    // Watchdog ends a hung run
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge user_clk);
        $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    // ======================================================================
    // Helpers and compare tasks
    // ======================================================================
    function automatic fcp_msg_t random_msg();
        fcp_msg_t m;
        m.valid = 1'b1;
        m.vc    = vc_t'($urandom());
        m.fccl  = $urandom();
        m.qlen  = $urandom();
        m.fccr  = $urandom();
        return m;
    endfunction

    task automatic note_failure(input string what);
        $display("Error in %s: %s", test_name, what);
        errors++;
    endtask

    task automatic check_msg(input string name, input fcp_msg_t exp, input fcp_msg_t act);
        if (act !== exp) begin
            $display("Mismatch in %s: expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input count_t exp, input count_t act);
        if (act !== exp) begin
            $display("Mismatch in %s: expected %0d actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_total(input string name, input total_t exp, input total_t act);
        if (act !== exp) begin
            $display("Mismatch in %s: expected %0d actual %0d", name, exp, act);
            errors++;
        end
    endtask

    // One clock, then sample outputs and score any delivered message
    task automatic advance_cycle();
        fcp_msg_t exp;
        @(posedge user_clk);
        #STIM_DELAY;
        if (fcp_out.valid === 1'b1) begin
            delivered++;
            if (model_q.size() == 0) begin
                note_failure("message delivered when none was expected");
            end else begin
                exp = model_q.pop_front();
                check_msg(test_name, exp, fcp_out);
            end
        end
    endtask

    // Drives one random message
    // expect_out says if it should come out
    task automatic send_msg(input logic expect_out);
        fcp_in = random_msg();
        if (expect_out) begin
            model_q.push_back(fcp_in);
            exp_total++;
        end
        advance_cycle();
    endtask

    task automatic idle_cycles(input int n);
        fcp_in = '0;
        repeat (n) advance_cycle();
    endtask

    // Waits for the model queue to empty, then checks the running total
    task automatic drain_model(input int max_cycles);
        int waited;
        waited = 0;
        fcp_in = '0;
        while (model_q.size() != 0 && waited < max_cycles) begin
            advance_cycle();
            waited++;
        end
        if (model_q.size() != 0) begin
            note_failure($sformatf("%0d expected messages never arrived", model_q.size()));
            model_q.delete();
        end
        // Extra cycles catch stray deliveries
        idle_cycles(4);
        check_total({test_name, " total"}, exp_total, total_count);
    endtask

    task automatic begin_test(input string name);
        test_name      = name;
        test_err_start = errors;
    endtask

    task automatic end_test();
        if (errors == test_err_start) begin
            tests_passed++;
            $display("%s: passed", test_name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", test_name, errors - test_err_start);
        end
    endtask

    // ======================================================================
    // Tests
    // ======================================================================
    // Input during hold-off is ignored even with the drain side open
    // link_up comes after HOLDOFF_CYCLES
    task automatic test_holdoff();
        int cycles;
        begin_test("holdoff");
        cycles = 0;
        if (link_up !== 1'b0) note_failure("link_up high straight after reset");
        drain_en = 1'b1;
        while (link_up !== 1'b1 && cycles < 2 * HOLDOFF_CYCLES) begin
            send_msg(1'b0);
            cycles++;
        end
        check_count("holdoff link_up delay", count_t'(HOLDOFF_CYCLES), count_t'(cycles));
        idle_cycles(8);
        check_count("holdoff drops", '0, drop_count);
        drain_model(4);
        end_test();
    endtask

    // Each back-to-back message comes out exactly two cycles after it is sampled
    task automatic test_latency();
        logic exp_valid;
        begin_test("latency");
        drain_en = 1'b1;
        for (int i = 0; i < 22; i++) begin
            if (i < 20) send_msg(1'b1);
            else idle_cycles(1);
            exp_valid = (i >= 2);
            if (fcp_out.valid !== exp_valid) begin
                $display("Mismatch in latency: valid at cycle %0d expected %b actual %b",
                         i, exp_valid, fcp_out.valid);
                errors++;
            end
        end
        drain_model(8);
        end_test();
    endtask

    task automatic test_stall();
        int seen;
        begin_test("stall");
        drain_en = 1'b0;
        seen = delivered;
        repeat (10) send_msg(1'b1);
        idle_cycles(3);
        if (delivered != seen) note_failure("message delivered while drain_en was low");
        drain_en = 1'b1;
        drain_model(20);
        end_test();
    endtask

    // Queue fills and the five extra messages are lost
    task automatic test_overflow();
        int     seen;
        count_t drops;
        begin_test("overflow");
        drain_en = 1'b0;
        seen  = delivered;
        drops = drop_count;
        for (int i = 0; i < QUEUE_DEPTH + 5; i++) send_msg(i < QUEUE_DEPTH);
        idle_cycles(2);
        check_count("overflow drops", drops + count_t'(5), drop_count);
        if (delivered != seen) note_failure("message delivered while drain_en was low");
        drain_en = 1'b1;
        drain_model(QUEUE_DEPTH + 8);
        check_count("overflow drops after drain", drops + count_t'(5), drop_count);
        end_test();
    endtask

    // A message every cycle covers at least two full windows
    task automatic test_meter();
        begin_test("meter");
        drain_en = 1'b1;
        repeat (3 * RATE_WINDOW_CYCLES) send_msg(1'b1);
        check_count("meter rate", count_t'(RATE_WINDOW_CYCLES), msg_rate);
        drain_model(8);
        end_test();
    endtask

    initial begin
        seed_ret     = $urandom(SEED);
        rst_user_300 = 1'b1;
        fcp_in       = '0;
        drain_en     = 1'b0;
        repeat (RESET_CYCLES) @(posedge user_clk);
        #STIM_DELAY;
        rst_user_300 = 1'b0;
        test_holdoff();
        test_latency();
        test_stall();
        test_overflow();
        test_meter();
        $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== fcp_link_assert.sv ====
// Concurrent protocol checks on the link top level, attached to fcp_link_top by bind
module fcp_link_assert (
    input logic                   user_clk,
    input logic                   rst_user_300,
    input logic                   drain_en,
    input logic                   link_up,
    input fcp_link_pkg::fcp_msg_t fcp_out,
    input fcp_link_pkg::count_t   drop_count
);
    timeunit 1ns;
    timeprecision 1ps;

    // No delivery before the link is up
    no_early_delivery: assert property (@(posedge user_clk) disable iff (rst_user_300)
        fcp_out.valid |-> link_up)
        else $error("message delivered before link_up");

    // Drop counter only counts up
    drops_monotonic: assert property (@(posedge user_clk) disable iff (rst_user_300)
        drop_count >= $past(drop_count))
        else $error("drop_count decreased");

    // A stalled drain side gives no delivery on the next cycle
    stall_holds_output: assert property (@(posedge user_clk) disable iff (rst_user_300)
        !drain_en |=> !fcp_out.valid)
        else $error("message delivered while drain_en was low");

endmodule

bind fcp_link_top fcp_link_assert assert_i (
    .user_clk     (user_clk),
    .rst_user_300 (rst_user_300),
    .drain_en     (drain_en),
    .link_up      (link_up),
    .fcp_out      (fcp_out),
    .drop_count   (drop_count)
);

// ==== fcp_link_top.sv ====
// Top level of the flow-control link path: packer, beat queue, unpacker and rate meter
module fcp_link_top (
    input  logic                   user_clk,
    input  logic                   rst_user_300,
    input  fcp_link_pkg::fcp_msg_t fcp_in,
    input  logic                   drain_en,
    output fcp_link_pkg::fcp_msg_t fcp_out,
    output logic                   link_up,
    output fcp_link_pkg::count_t   drop_count,
    output fcp_link_pkg::total_t   total_count,
    output fcp_link_pkg::count_t   msg_rate
);
    import fcp_link_pkg::*;

    // Packer to queue
    beat_t wr_beat;
    logic  wr_en;
    logic  full;

    // Queue to unpacker
    beat_t rd_beat;
    logic  rd_en;
    logic  empty;

    // ======================================================================
    // Ingress
    // ======================================================================
    fcp_ingress_packer u_packer (
        .user_clk     (user_clk),
        .rst_user_300 (rst_user_300),
        .fcp_in       (fcp_in),
        .full         (full),
        .wr_beat      (wr_beat),
        .wr_en        (wr_en),
        .link_up      (link_up),
        .drop_count   (drop_count)
    );

    // ======================================================================
    // Beat buffering
    // ======================================================================
    fcp_beat_queue u_queue (
        .user_clk     (user_clk),
        .rst_user_300 (rst_user_300),
        .wr_beat      (wr_beat),
        .wr_en        (wr_en),
        .rd_en        (rd_en),
        .rd_beat      (rd_beat),
        .full         (full),
        .empty        (empty)
    );

    // ======================================================================
    // Egress and metering
    // ======================================================================
    fcp_egress_unpacker u_unpacker (
        .user_clk     (user_clk),
        .rst_user_300 (rst_user_300),
        .rd_beat      (rd_beat),
        .empty        (empty),
        .drain_en     (drain_en),
        .rd_en        (rd_en),
        .fcp_out      (fcp_out)
    );

    // Meter watches the delivered strobe
    fcp_rate_meter u_meter (
        .user_clk     (user_clk),
        .rst_user_300 (rst_user_300),
        .msg_valid    (fcp_out.valid),
        .total_count  (total_count),
        .msg_rate     (msg_rate)
    );

endmodule

// ==== fcp_rate_meter.sv ====
// Delivered-message meter: running total and per-window count of messages
module fcp_rate_meter (
    input  logic                 user_clk,
    input  logic                 rst_user_300,
    input  logic                 msg_valid,
    output fcp_link_pkg::total_t total_count,
    output fcp_link_pkg::count_t msg_rate
);
    import fcp_link_pkg::*;

    total_t      total_q;
    window_cnt_t window_q;
    count_t      in_window_q;
    count_t      rate_q;
    logic        window_end;

    // ======================================================================
    // Running total
    // ======================================================================
    always_ff @(posedge user_clk) begin
        if (rst_user_300) begin
            total_q <= '0;
        end else if (msg_valid) begin
            total_q <= total_q + total_t'(1);
        end
    end

    // ======================================================================
    // Window timing
    // ======================================================================
    // Free running from reset, wraps every window
    always_ff @(posedge user_clk) begin
        if (rst_user_300) begin
            window_q <= '0;
        end else if (window_end) begin
            window_q <= '0;
        end else begin
            window_q <= window_q + window_cnt_t'(1);
        end
    end

    assign window_end = (window_q == window_cnt_t'(RATE_WINDOW_CYCLES - 1));

    // ======================================================================
    // Per-window count
    // ======================================================================
    // A message on the last cycle still belongs to the closing window
    always_ff @(posedge user_clk) begin
        if (rst_user_300) begin
            in_window_q <= '0;
            rate_q      <= '0;
        end else if (window_end) begin
            rate_q      <= in_window_q + count_t'(msg_valid);
            in_window_q <= '0;
        end else begin
            in_window_q <= in_window_q + count_t'(msg_valid);
        end
    end

    assign total_count = total_q;
    assign msg_rate    = rate_q;

endmodule

// ==== fcp_egress_unpacker.sv ====
// Egress side: drains the beat queue under drain_en and registers the recovered message
module fcp_egress_unpacker (
    input  logic                   user_clk,
    input  logic                   rst_user_300,
    input  fcp_link_pkg::beat_t    rd_beat,
    input  logic                   empty,
    input  logic                   drain_en,
    output logic                   rd_en,
    output fcp_link_pkg::fcp_msg_t fcp_out
);
    import fcp_link_pkg::*;

    fcp_msg_t msg_q;
    fcp_msg_t msg_d;

    // ======================================================================
    // Read request
    // ======================================================================
    // Only place where empty is checked
    assign rd_en = drain_en && !empty;

    // ======================================================================
    // Field extraction
    // ======================================================================
    always_comb begin
        msg_d.valid = rd_en;
        msg_d.vc    = rd_beat[BEAT_VC_LSB   +: VC_W];
        msg_d.fccl  = rd_beat[BEAT_FCCL_LSB +: STAT_W];
        msg_d.qlen  = rd_beat[BEAT_QLEN_LSB +: STAT_W];
        msg_d.fccr  = rd_beat[BEAT_FCCR_LSB +: STAT_W];
    end

    // ======================================================================
    // Output register
    // ======================================================================
    // Fields hold their last value between reads, valid is a one-cycle strobe
    always_ff @(posedge user_clk) begin
        if (rd_en) begin
            msg_q.vc   <= msg_d.vc;
            msg_q.fccl <= msg_d.fccl;
            msg_q.qlen <= msg_d.qlen;
            msg_q.fccr <= msg_d.fccr;
        end
        if (rst_user_300) begin
            msg_q.valid <= 1'b0;
        end else begin
            msg_q.valid <= msg_d.valid;
        end
    end

    assign fcp_out = msg_q;

endmodule

// ==== fcp_beat_queue.sv ====
// Synchronous first-word-fall-through queue of link beats, head shown combinationally
module fcp_beat_queue (
    input  logic                user_clk,
    input  logic                rst_user_300,
    input  fcp_link_pkg::beat_t wr_beat,
    input  logic                wr_en,
    input  logic                rd_en,
    output fcp_link_pkg::beat_t rd_beat,
    output logic                full,
    output logic                empty
);
    import fcp_link_pkg::*;

    // Storage
    beat_t   mem [QUEUE_DEPTH];

    // Pointers wrap on their own since the depth is a power of two
    qaddr_t  wr_ptr_q;
    qaddr_t  rd_ptr_q;
    // Number of beats held
    qcount_t count_q;

    // ======================================================================
    // Storage write
    // ======================================================================
    always_ff @(posedge user_clk) begin
        if (wr_en) begin
            mem[wr_ptr_q] <= wr_beat;
        end
    end

    // ======================================================================
    // Pointers
    // ======================================================================
    always_ff @(posedge user_clk) begin
        if (rst_user_300) begin
            wr_ptr_q <= '0;
        end else if (wr_en) begin
            wr_ptr_q <= wr_ptr_q + qaddr_t'(1);
        end
    end

    always_ff @(posedge user_clk) begin
        if (rst_user_300) begin
            rd_ptr_q <= '0;
        end else if (rd_en) begin
            rd_ptr_q <= rd_ptr_q + qaddr_t'(1);
        end
    end

    // ======================================================================
    // Occupancy
    // ======================================================================
    // Simultaneous read and write leaves the count unchanged
    always_ff @(posedge user_clk) begin
        if (rst_user_300) begin
            count_q <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10: begin
                    count_q <= count_q + qcount_t'(1);
                end
                2'b01: begin
                    count_q <= count_q - qcount_t'(1);
                end
                default: begin
                    count_q <= count_q;
                end
            endcase
        end
    end

    // Status flags
    assign full  = (count_q == qcount_t'(QUEUE_DEPTH));
    assign empty = (count_q == '0);

    // Head entry, valid whenever not empty
    assign rd_beat = mem[rd_ptr_q];

endmodule

// ==== fcp_ingress_packer.sv ====
// Ingress side: start-up hold-off, packs messages into link beats, counts queue-full drops
module fcp_ingress_packer (
    input  logic                  user_clk,
    input  logic                  rst_user_300,
    input  fcp_link_pkg::fcp_msg_t fcp_in,
    input  logic                  full,
    output fcp_link_pkg::beat_t   wr_beat,
    output logic                  wr_en,
    output logic                  link_up,
    output fcp_link_pkg::count_t  drop_count
);
    import fcp_link_pkg::*;

    packer_state_e state_q;
    holdoff_cnt_t  holdoff_q;
    beat_t         beat_q;
    logic          beat_valid_q;
    count_t        drop_q;

    // ======================================================================
    // Hold-off FSM
    // ======================================================================
    // Counts from reset, then stays in RUN until the next reset
    always_ff @(posedge user_clk) begin
        if (rst_user_300) begin
            state_q   <= HOLDOFF;
            holdoff_q <= '0;
        end else begin
            case (state_q)
                HOLDOFF: begin
                    holdoff_q <= holdoff_q + holdoff_cnt_t'(1);
                    // Last hold-off cycle
                    if (holdoff_q == holdoff_cnt_t'(HOLDOFF_CYCLES - 1)) begin
                        state_q <= RUN;
                    end
                end
                default: begin
                    state_q <= RUN;
                end
            endcase
        end
    end

    assign link_up = (state_q == RUN);

    // ======================================================================
    // Beat register
    // ======================================================================
    // Strobe only, input is dropped silently during hold-off
    always_ff @(posedge user_clk) begin
        if (rst_user_300) begin
            beat_valid_q <= 1'b0;
        end else begin
            beat_valid_q <= fcp_in.valid && (state_q == RUN);
        end
    end

    // Payload: place each field at its beat offset, rest of the beat zero
    always_ff @(posedge user_clk) begin
        if (fcp_in.valid) begin
            beat_q                                <= '0;
            beat_q[BEAT_VC_LSB   +: VC_W]         <= fcp_in.vc;
            beat_q[BEAT_FCCL_LSB +: STAT_W]       <= fcp_in.fccl;
            beat_q[BEAT_QLEN_LSB +: STAT_W]       <= fcp_in.qlen;
            beat_q[BEAT_FCCR_LSB +: STAT_W]       <= fcp_in.fccr;
        end
    end

    assign wr_beat = beat_q;
    // Write gated by full here, the queue trusts it
    assign wr_en   = beat_valid_q && !full;

    // ======================================================================
    // Drop counter
    // ======================================================================
    // A pending beat that meets a full queue is lost
    always_ff @(posedge user_clk) begin
        if (rst_user_300) begin
            drop_q <= '0;
        end else if (beat_valid_q && full) begin
            drop_q <= drop_q + count_t'(1);
        end
    end

    assign drop_count = drop_q;

endmodule

// ==== fcp_link_pkg.sv ====
// Shared widths, field types, message and beat layout for the flow-control link path
package fcp_link_pkg;

    // ======================================================================
    // Field widths
    // ======================================================================
    localparam int VC_W    = 16;
    localparam int STAT_W  = 32;
    localparam int BEAT_W  = 512;
    localparam int COUNT_W = 32;
    localparam int TOTAL_W = 64;

    // Virtual channel index
    typedef logic [VC_W-1:0]    vc_t;
    // One credit limit, queue length or credit rate field
    typedef logic [STAT_W-1:0]  stat_t;
    // One link beat
    typedef logic [BEAT_W-1:0]  beat_t;
    // Per-window rate and drop counter
    typedef logic [COUNT_W-1:0] count_t;
    // Running message total
    typedef logic [TOTAL_W-1:0] total_t;

    // Flow-control message, 113 bits, valid in the MSB
    typedef struct packed {
        logic  valid;
        vc_t   vc;
        stat_t fccl;
        stat_t qlen;
        stat_t fccr;
    } fcp_msg_t;

    // ======================================================================
    // Beat layout
    // ======================================================================
    // Fields sit at the bottom of the beat, all higher bits are zero
    localparam int BEAT_VC_LSB   = 0;
    localparam int BEAT_FCCL_LSB = 16;
    localparam int BEAT_QLEN_LSB = 48;
    localparam int BEAT_FCCR_LSB = 80;

    // ======================================================================
    // Beat queue
    // ======================================================================
    localparam int QUEUE_DEPTH = 16;
    localparam int QADDR_W     = $clog2(QUEUE_DEPTH);
    // One extra bit so a full queue can be told from an empty one
    localparam int QCOUNT_W    = QADDR_W + 1;

    typedef logic [QADDR_W-1:0]  qaddr_t;
    typedef logic [QCOUNT_W-1:0] qcount_t;

    // ======================================================================
    // Start-up hold-off and rate window
    // ======================================================================
    // Short stand-in for the long power-up wait of the hardware link
    localparam int HOLDOFF_CYCLES     = 64;
    localparam int HOLDOFF_W          = $clog2(HOLDOFF_CYCLES);
    // Metering window, kept short for simulation
    localparam int RATE_WINDOW_CYCLES = 256;
    localparam int WINDOW_W           = $clog2(RATE_WINDOW_CYCLES);

    typedef logic [HOLDOFF_W-1:0] holdoff_cnt_t;
    typedef logic [WINDOW_W-1:0]  window_cnt_t;

    // Packer mode
    typedef enum logic {
        HOLDOFF,
        RUN
    } packer_state_e;

endpackage
